// ==== gfx_dcr_pkg.sv ====
package gfx_dcr_pkg;

    typedef logic [11:0] dcr_addr_t;
    typedef logic [31:0] dcr_data_t;
    typedef logic [3:0]  dcr_offset_t;

    typedef logic [3:0]  log_dim_t;
    typedef logic [2:0]  tex_format_t;
    typedef logic [3:0]  tex_wrap_t;        // V mode in [3:2], U mode in [1:0].

    typedef logic [3:0]  rop_mask_t;        // One enable per colour channel.
    typedef logic [2:0]  blend_mode_t;

    localparam dcr_addr_t DCR_COMMIT       = 12'h001;

    // End addresses of the bank ranges are exclusive.
    localparam dcr_addr_t DCR_TEX_BEGIN    = 12'h010;
    localparam dcr_addr_t DCR_TEX_END      = 12'h016;
    localparam dcr_addr_t DCR_RASTER_BEGIN = 12'h020;
    localparam dcr_addr_t DCR_RASTER_END   = 12'h024;
    localparam dcr_addr_t DCR_ROP_BEGIN    = 12'h030;
    localparam dcr_addr_t DCR_ROP_END      = 12'h035;

    localparam dcr_offset_t TEX_STAGE          = 4'd0;
    localparam dcr_offset_t TEX_ADDR           = 4'd1;
    localparam dcr_offset_t TEX_LOGDIM         = 4'd2;  // Width in [3:0], height in [19:16].
    localparam dcr_offset_t TEX_FORMAT         = 4'd3;
    localparam dcr_offset_t TEX_FILTER         = 4'd4;
    localparam dcr_offset_t TEX_WRAP           = 4'd5;

    localparam dcr_offset_t RASTER_TBUF_ADDR   = 4'd0;
    localparam dcr_offset_t RASTER_TILE_COUNT  = 4'd1;
    localparam dcr_offset_t RASTER_PBUF_ADDR   = 4'd2;
    localparam dcr_offset_t RASTER_PBUF_STRIDE = 4'd3;

    localparam dcr_offset_t ROP_CBUF_ADDR      = 4'd0;
    localparam dcr_offset_t ROP_CBUF_PITCH     = 4'd1;
    localparam dcr_offset_t ROP_CBUF_WRITEMASK = 4'd2;
    localparam dcr_offset_t ROP_ZBUF_ADDR      = 4'd3;
    localparam dcr_offset_t ROP_BLEND_MODE     = 4'd4;

endpackage

// ==== gfx_state_if.sv ====
interface tex_state_if #(
    parameter int NUM_STAGES = 2
);
    import gfx_dcr_pkg::*;

    dcr_data_t   addr       [NUM_STAGES];
    log_dim_t    log_width  [NUM_STAGES];
    log_dim_t    log_height [NUM_STAGES];
    tex_format_t format     [NUM_STAGES];
    logic        filter     [NUM_STAGES];   // Bilinear when set.
    tex_wrap_t   wrap       [NUM_STAGES];

    modport bank (output addr, log_width, log_height, format, filter, wrap);
    modport commit (input addr, log_width, log_height, format, filter, wrap);

endinterface

interface raster_state_if;
    import gfx_dcr_pkg::*;

    dcr_data_t tbuf_addr;
    dcr_data_t tile_count;
    dcr_data_t pbuf_addr;
    dcr_data_t pbuf_stride;

    modport bank (output tbuf_addr, tile_count, pbuf_addr, pbuf_stride);
    modport commit (input tbuf_addr, tile_count, pbuf_addr, pbuf_stride);

endinterface

interface rop_state_if;
    import gfx_dcr_pkg::*;

    dcr_data_t   cbuf_addr;
    dcr_data_t   cbuf_pitch;
    rop_mask_t   cbuf_writemask;
    dcr_data_t   zbuf_addr;
    blend_mode_t blend_mode;

    modport bank (output cbuf_addr, cbuf_pitch, cbuf_writemask, zbuf_addr, blend_mode);
    modport commit (input cbuf_addr, cbuf_pitch, cbuf_writemask, zbuf_addr, blend_mode);

endinterface

// ==== dcr_write_decoder.sv ====
module dcr_write_decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dcr_wr_valid,
    input  gfx_dcr_pkg::dcr_addr_t dcr_wr_addr,
    output logic                   tex_wr,
    output logic                   raster_wr,
    output logic                   rop_wr,
    output logic                   commit_pulse,
    output gfx_dcr_pkg::dcr_offset_t bank_offset,
    output logic                   dcr_error,
    output gfx_dcr_pkg::dcr_addr_t dcr_error_addr
);
    import gfx_dcr_pkg::*;

    logic      is_tex;
    logic      is_raster;
    logic      is_rop;
    logic      is_commit;
    logic      bad_write;
    dcr_addr_t bank_base;

    assign is_tex    = (dcr_wr_addr >= DCR_TEX_BEGIN) && (dcr_wr_addr < DCR_TEX_END);
    assign is_raster = (dcr_wr_addr >= DCR_RASTER_BEGIN) && (dcr_wr_addr < DCR_RASTER_END);
    assign is_rop    = (dcr_wr_addr >= DCR_ROP_BEGIN) && (dcr_wr_addr < DCR_ROP_END);
    assign is_commit = (dcr_wr_addr == DCR_COMMIT);

    assign tex_wr       = dcr_wr_valid && is_tex;
    assign raster_wr    = dcr_wr_valid && is_raster;
    assign rop_wr       = dcr_wr_valid && is_rop;
    assign commit_pulse = dcr_wr_valid && is_commit;

    assign bad_write = dcr_wr_valid && !(is_tex || is_raster || is_rop || is_commit);

    always_comb begin
        bank_base = '0;
        if (is_tex) begin
            bank_base = DCR_TEX_BEGIN;
        end else if (is_raster) begin
            bank_base = DCR_RASTER_BEGIN;
        end else if (is_rop) begin
            bank_base = DCR_ROP_BEGIN;
        end
    end

    assign bank_offset = dcr_offset_t'(dcr_wr_addr - bank_base);   // Ranges are under 16 deep.

    always_ff @(posedge clk) begin
        if (reset) begin
            dcr_error      <= 1'b0;
            dcr_error_addr <= '0;
        end else if (bad_write) begin
            dcr_error <= 1'b1;                  // Sticky until reset.
            if (!dcr_error) begin
                dcr_error_addr <= dcr_wr_addr;  // First offender only.
            end
        end
    end

endmodule

// ==== tex_dcr_bank.sv ====
module tex_dcr_bank #(
    parameter int NUM_STAGES = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr,
    input  gfx_dcr_pkg::dcr_offset_t offset,
    input  gfx_dcr_pkg::dcr_data_t   data,
    tex_state_if.bank                state
);
    import gfx_dcr_pkg::*;

    localparam int SEL_W = (NUM_STAGES > 1) ? $clog2(NUM_STAGES) : 1;

    logic [SEL_W-1:0] stage;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage            <= '0;
            state.addr       <= '{default: '0};
            state.log_width  <= '{default: '0};
            state.log_height <= '{default: '0};
            state.format     <= '{default: '0};
            state.filter     <= '{default: 1'b0};
            state.wrap       <= '{default: '0};
        end else if (wr) begin
            if (offset == TEX_STAGE) begin
                stage <= (NUM_STAGES > 1) ? data[SEL_W-1:0] : '0;
            end
            // Out-of-range stage indices match no slot.
            for (int s = 0; s < NUM_STAGES; s++) begin
                if (int'(stage) == s) begin
                    case (offset)
                        TEX_ADDR: state.addr[s] <= data;
                        TEX_LOGDIM: begin
                            state.log_width[s]  <= data[3:0];
                            state.log_height[s] <= data[19:16];
                        end
                        TEX_FORMAT: state.format[s] <= data[2:0];
                        TEX_FILTER: state.filter[s] <= data[0];
                        TEX_WRAP:   state.wrap[s]   <= data[3:0];
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== raster_dcr_bank.sv ====
module raster_dcr_bank (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr,
    input  gfx_dcr_pkg::dcr_offset_t offset,
    input  gfx_dcr_pkg::dcr_data_t   data,
    raster_state_if.bank             state
);
    import gfx_dcr_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            state.tbuf_addr   <= '0;
            state.tile_count  <= '0;
            state.pbuf_addr   <= '0;
            state.pbuf_stride <= '0;
        end else if (wr) begin
            case (offset)
                RASTER_TBUF_ADDR:   state.tbuf_addr   <= data;
                RASTER_TILE_COUNT:  state.tile_count  <= data;
                RASTER_PBUF_ADDR:   state.pbuf_addr   <= data;
                RASTER_PBUF_STRIDE: state.pbuf_stride <= data;  // Bytes per primitive.
                default: ;
            endcase
        end
    end

endmodule

// ==== rop_dcr_bank.sv ====
module rop_dcr_bank (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr,
    input  gfx_dcr_pkg::dcr_offset_t offset,
    input  gfx_dcr_pkg::dcr_data_t   data,
    rop_state_if.bank                state
);
    import gfx_dcr_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            state.cbuf_addr      <= '0;
            state.cbuf_pitch     <= '0;
            state.cbuf_writemask <= '0;
            state.zbuf_addr      <= '0;
            state.blend_mode     <= '0;
        end else if (wr) begin
            case (offset)
                ROP_CBUF_ADDR:      state.cbuf_addr      <= data;
                ROP_CBUF_PITCH:     state.cbuf_pitch     <= data;
                ROP_CBUF_WRITEMASK: state.cbuf_writemask <= data[3:0];
                ROP_ZBUF_ADDR:      state.zbuf_addr      <= data;
                ROP_BLEND_MODE:     state.blend_mode     <= data[2:0];
                default: ;
            endcase
        end
    end

endmodule

// ==== dcr_state_commit.sv ====
module dcr_state_commit #(
    parameter int NUM_STAGES = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     commit_pulse,
    tex_state_if.commit              tex,
    raster_state_if.commit           raster,
    rop_state_if.commit              rop,
    output gfx_dcr_pkg::dcr_data_t   tex_addr       [NUM_STAGES],
    output gfx_dcr_pkg::log_dim_t    tex_log_width  [NUM_STAGES],
    output gfx_dcr_pkg::log_dim_t    tex_log_height [NUM_STAGES],
    output gfx_dcr_pkg::tex_format_t tex_format     [NUM_STAGES],
    output logic                     tex_filter     [NUM_STAGES],
    output gfx_dcr_pkg::tex_wrap_t   tex_wrap       [NUM_STAGES],
    output gfx_dcr_pkg::dcr_data_t   raster_tbuf_addr,
    output gfx_dcr_pkg::dcr_data_t   raster_tile_count,
    output gfx_dcr_pkg::dcr_data_t   raster_pbuf_addr,
    output gfx_dcr_pkg::dcr_data_t   raster_pbuf_stride,
    output gfx_dcr_pkg::dcr_data_t   rop_cbuf_addr,
    output gfx_dcr_pkg::dcr_data_t   rop_cbuf_pitch,
    output gfx_dcr_pkg::rop_mask_t   rop_cbuf_writemask,
    output gfx_dcr_pkg::dcr_data_t   rop_zbuf_addr,
    output gfx_dcr_pkg::blend_mode_t rop_blend_mode,
    output logic                     state_updated
);

    // All units switch to the new configuration on the same edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            tex_addr           <= '{default: '0};
            tex_log_width      <= '{default: '0};
            tex_log_height     <= '{default: '0};
            tex_format         <= '{default: '0};
            tex_filter         <= '{default: 1'b0};
            tex_wrap           <= '{default: '0};
            raster_tbuf_addr   <= '0;
            raster_tile_count  <= '0;
            raster_pbuf_addr   <= '0;
            raster_pbuf_stride <= '0;
            rop_cbuf_addr      <= '0;
            rop_cbuf_pitch     <= '0;
            rop_cbuf_writemask <= '0;
            rop_zbuf_addr      <= '0;
            rop_blend_mode     <= '0;
            state_updated      <= 1'b0;
        end else begin
            state_updated <= commit_pulse;      // High the cycle after each commit.
            if (commit_pulse) begin
                tex_addr           <= tex.addr;
                tex_log_width      <= tex.log_width;
                tex_log_height     <= tex.log_height;
                tex_format         <= tex.format;
                tex_filter         <= tex.filter;
                tex_wrap           <= tex.wrap;
                raster_tbuf_addr   <= raster.tbuf_addr;
                raster_tile_count  <= raster.tile_count;
                raster_pbuf_addr   <= raster.pbuf_addr;
                raster_pbuf_stride <= raster.pbuf_stride;
                rop_cbuf_addr      <= rop.cbuf_addr;
                rop_cbuf_pitch     <= rop.cbuf_pitch;
                rop_cbuf_writemask <= rop.cbuf_writemask;
                rop_zbuf_addr      <= rop.zbuf_addr;
                rop_blend_mode     <= rop.blend_mode;
            end
        end
    end

endmodule

// ==== gfx_dcr_top.sv ====
module gfx_dcr_top #(
    parameter int NUM_STAGES = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dcr_wr_valid,
    input  gfx_dcr_pkg::dcr_addr_t   dcr_wr_addr,
    input  gfx_dcr_pkg::dcr_data_t   dcr_wr_data,
    output gfx_dcr_pkg::dcr_data_t   tex_addr       [NUM_STAGES],
    output gfx_dcr_pkg::log_dim_t    tex_log_width  [NUM_STAGES],
    output gfx_dcr_pkg::log_dim_t    tex_log_height [NUM_STAGES],
    output gfx_dcr_pkg::tex_format_t tex_format     [NUM_STAGES],
    output logic                     tex_filter     [NUM_STAGES],
    output gfx_dcr_pkg::tex_wrap_t   tex_wrap       [NUM_STAGES],
    output gfx_dcr_pkg::dcr_data_t   raster_tbuf_addr,
    output gfx_dcr_pkg::dcr_data_t   raster_tile_count,
    output gfx_dcr_pkg::dcr_data_t   raster_pbuf_addr,
    output gfx_dcr_pkg::dcr_data_t   raster_pbuf_stride,
    output gfx_dcr_pkg::dcr_data_t   rop_cbuf_addr,
    output gfx_dcr_pkg::dcr_data_t   rop_cbuf_pitch,
    output gfx_dcr_pkg::rop_mask_t   rop_cbuf_writemask,
    output gfx_dcr_pkg::dcr_data_t   rop_zbuf_addr,
    output gfx_dcr_pkg::blend_mode_t rop_blend_mode,
    output logic                     state_updated,
    output logic                     dcr_error,
    output gfx_dcr_pkg::dcr_addr_t   dcr_error_addr
);
    import gfx_dcr_pkg::*;

    logic        tex_wr;
    logic        raster_wr;
    logic        rop_wr;
    logic        commit_pulse;
    dcr_offset_t bank_offset;

    tex_state_if #(.NUM_STAGES(NUM_STAGES)) tex_state ();
    raster_state_if raster_state ();
    rop_state_if    rop_state ();

    dcr_write_decoder u_decoder (
        .clk            (clk),
        .reset          (reset),
        .dcr_wr_valid   (dcr_wr_valid),
        .dcr_wr_addr    (dcr_wr_addr),
        .tex_wr         (tex_wr),
        .raster_wr      (raster_wr),
        .rop_wr         (rop_wr),
        .commit_pulse   (commit_pulse),
        .bank_offset    (bank_offset),
        .dcr_error      (dcr_error),
        .dcr_error_addr (dcr_error_addr)
    );

    tex_dcr_bank #(.NUM_STAGES(NUM_STAGES)) u_tex_bank (
        .clk    (clk),
        .reset  (reset),
        .wr     (tex_wr),
        .offset (bank_offset),
        .data   (dcr_wr_data),
        .state  (tex_state.bank)
    );

    raster_dcr_bank u_raster_bank (
        .clk    (clk),
        .reset  (reset),
        .wr     (raster_wr),
        .offset (bank_offset),
        .data   (dcr_wr_data),
        .state  (raster_state.bank)
    );

    rop_dcr_bank u_rop_bank (
        .clk    (clk),
        .reset  (reset),
        .wr     (rop_wr),
        .offset (bank_offset),
        .data   (dcr_wr_data),
        .state  (rop_state.bank)
    );

    dcr_state_commit #(.NUM_STAGES(NUM_STAGES)) u_commit (
        .clk                (clk),
        .reset              (reset),
        .commit_pulse       (commit_pulse),
        .tex                (tex_state.commit),
        .raster             (raster_state.commit),
        .rop                (rop_state.commit),
        .tex_addr           (tex_addr),
        .tex_log_width      (tex_log_width),
        .tex_log_height     (tex_log_height),
        .tex_format         (tex_format),
        .tex_filter         (tex_filter),
        .tex_wrap           (tex_wrap),
        .raster_tbuf_addr   (raster_tbuf_addr),
        .raster_tile_count  (raster_tile_count),
        .raster_pbuf_addr   (raster_pbuf_addr),
        .raster_pbuf_stride (raster_pbuf_stride),
        .rop_cbuf_addr      (rop_cbuf_addr),
        .rop_cbuf_pitch     (rop_cbuf_pitch),
        .rop_cbuf_writemask (rop_cbuf_writemask),
        .rop_zbuf_addr      (rop_zbuf_addr),
        .rop_blend_mode     (rop_blend_mode),
        .state_updated      (state_updated)
    );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8,
    parameter int DRIVE_DELAY  = 10
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) reset = 1'b0;    // Released like any other input.
    end

endmodule

// ==== tb_gfx_dcr_checker.sv ====
module tb_gfx_dcr_checker #(
    parameter int NUM_STAGES = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dcr_wr_valid,
    input  gfx_dcr_pkg::dcr_addr_t   dcr_wr_addr,
    input  gfx_dcr_pkg::dcr_data_t   dcr_wr_data,
    input  gfx_dcr_pkg::dcr_data_t   tex_addr       [NUM_STAGES],
    input  gfx_dcr_pkg::log_dim_t    tex_log_width  [NUM_STAGES],
    input  gfx_dcr_pkg::log_dim_t    tex_log_height [NUM_STAGES],
    input  gfx_dcr_pkg::tex_format_t tex_format     [NUM_STAGES],
    input  logic                     tex_filter     [NUM_STAGES],
    input  gfx_dcr_pkg::tex_wrap_t   tex_wrap       [NUM_STAGES],
    input  gfx_dcr_pkg::dcr_data_t   raster_tbuf_addr,
    input  gfx_dcr_pkg::dcr_data_t   raster_tile_count,
    input  gfx_dcr_pkg::dcr_data_t   raster_pbuf_addr,
    input  gfx_dcr_pkg::dcr_data_t   raster_pbuf_stride,
    input  gfx_dcr_pkg::dcr_data_t   rop_cbuf_addr,
    input  gfx_dcr_pkg::dcr_data_t   rop_cbuf_pitch,
    input  gfx_dcr_pkg::rop_mask_t   rop_cbuf_writemask,
    input  gfx_dcr_pkg::dcr_data_t   rop_zbuf_addr,
    input  gfx_dcr_pkg::blend_mode_t rop_blend_mode,
    input  logic                     state_updated,
    input  logic                     dcr_error,
    input  gfx_dcr_pkg::dcr_addr_t   dcr_error_addr,
    output int                       check_count,
    output int                       error_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import gfx_dcr_pkg::*;

    localparam dcr_data_t STAGE_MASK = dcr_data_t'((1 << $clog2(NUM_STAGES)) - 1);

    // Raw register words indexed by bank offset.
    dcr_data_t   pend_tex [NUM_STAGES][16];
    dcr_data_t   act_tex  [NUM_STAGES][16];
    dcr_data_t   pend_ras [16];
    dcr_data_t   act_ras  [16];
    dcr_data_t   pend_rop [16];
    dcr_data_t   act_rop  [16];
    int          stage_sel;
    logic        exp_updated;
    logic        exp_error;
    dcr_addr_t   exp_error_addr;
    dcr_offset_t off;

    function automatic logic in_range(input dcr_addr_t a, input dcr_addr_t lo,
                                      input dcr_addr_t hi);
        return (a >= lo) && (a < hi);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    initial begin
        check_count = 0;
        error_count = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            foreach (pend_tex[s, r]) begin
                pend_tex[s][r] = '0;
                act_tex[s][r]  = '0;
            end
            foreach (pend_ras[r]) begin
                pend_ras[r] = '0;
                act_ras[r]  = '0;
                pend_rop[r] = '0;
                act_rop[r]  = '0;
            end
            stage_sel      = 0;
            exp_updated    = 1'b0;
            exp_error      = 1'b0;
            exp_error_addr = '0;
        end else begin
            exp_updated = 1'b0;
            if (dcr_wr_valid) begin
                if (dcr_wr_addr == DCR_COMMIT) begin
                    act_tex     = pend_tex;     // Whole configuration at once.
                    act_ras     = pend_ras;
                    act_rop     = pend_rop;
                    exp_updated = 1'b1;
                end else if (in_range(dcr_wr_addr, DCR_TEX_BEGIN, DCR_TEX_END)) begin
                    off = dcr_offset_t'(dcr_wr_addr - DCR_TEX_BEGIN);
                    if (off == TEX_STAGE) begin
                        stage_sel = int'(dcr_wr_data & STAGE_MASK);
                    end else if (stage_sel < NUM_STAGES) begin
                        pend_tex[stage_sel][off] = dcr_wr_data;
                    end
                end else if (in_range(dcr_wr_addr, DCR_RASTER_BEGIN, DCR_RASTER_END)) begin
                    off = dcr_offset_t'(dcr_wr_addr - DCR_RASTER_BEGIN);
                    pend_ras[off] = dcr_wr_data;
                end else if (in_range(dcr_wr_addr, DCR_ROP_BEGIN, DCR_ROP_END)) begin
                    off = dcr_offset_t'(dcr_wr_addr - DCR_ROP_BEGIN);
                    pend_rop[off] = dcr_wr_data;
                end else begin
                    if (!exp_error) begin
                        exp_error_addr = dcr_wr_addr;
                    end
                    exp_error = 1'b1;
                end
            end
        end
    end

    // Compared half a period away from any update.
    always @(negedge clk) begin
        for (int s = 0; s < NUM_STAGES; s++) begin
            check_value($sformatf("tex_addr[%0d]", s), act_tex[s][TEX_ADDR], tex_addr[s]);
            check_value($sformatf("tex_log_width[%0d]", s),
                        32'(act_tex[s][TEX_LOGDIM][3:0]), 32'(tex_log_width[s]));
            check_value($sformatf("tex_log_height[%0d]", s),
                        32'(act_tex[s][TEX_LOGDIM][19:16]), 32'(tex_log_height[s]));
            check_value($sformatf("tex_format[%0d]", s),
                        32'(act_tex[s][TEX_FORMAT][2:0]), 32'(tex_format[s]));
            check_value($sformatf("tex_filter[%0d]", s),
                        32'(act_tex[s][TEX_FILTER][0]), 32'(tex_filter[s]));
            check_value($sformatf("tex_wrap[%0d]", s),
                        32'(act_tex[s][TEX_WRAP][3:0]), 32'(tex_wrap[s]));
        end
        check_value("raster_tbuf_addr", act_ras[RASTER_TBUF_ADDR], raster_tbuf_addr);
        check_value("raster_tile_count", act_ras[RASTER_TILE_COUNT], raster_tile_count);
        check_value("raster_pbuf_addr", act_ras[RASTER_PBUF_ADDR], raster_pbuf_addr);
        check_value("raster_pbuf_stride", act_ras[RASTER_PBUF_STRIDE], raster_pbuf_stride);
        check_value("rop_cbuf_addr", act_rop[ROP_CBUF_ADDR], rop_cbuf_addr);
        check_value("rop_cbuf_pitch", act_rop[ROP_CBUF_PITCH], rop_cbuf_pitch);
        check_value("rop_cbuf_writemask", 32'(act_rop[ROP_CBUF_WRITEMASK][3:0]),
                    32'(rop_cbuf_writemask));
        check_value("rop_zbuf_addr", act_rop[ROP_ZBUF_ADDR], rop_zbuf_addr);
        check_value("rop_blend_mode", 32'(act_rop[ROP_BLEND_MODE][2:0]), 32'(rop_blend_mode));
        check_value("state_updated", 32'(exp_updated), 32'(state_updated));
        check_value("dcr_error", 32'(exp_error), 32'(dcr_error));
        check_value("dcr_error_addr", 32'(exp_error_addr), 32'(dcr_error_addr));
    end

endmodule

// ==== tb_gfx_dcr.sv ====
module tb_gfx_dcr;
    timeunit 1ns;
    timeprecision 100ps;
    import gfx_dcr_pkg::*;

    localparam int NUM_STAGES    = 2;
    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int NUM_CYCLES    = 3000;
    localparam int DRIVE_DELAY   = 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CYCLES + 100;

    logic        clk;
    logic        reset;
    logic        dcr_wr_valid;
    dcr_addr_t   dcr_wr_addr;
    dcr_data_t   dcr_wr_data;
    dcr_data_t   tex_addr       [NUM_STAGES];
    log_dim_t    tex_log_width  [NUM_STAGES];
    log_dim_t    tex_log_height [NUM_STAGES];
    tex_format_t tex_format     [NUM_STAGES];
    logic        tex_filter     [NUM_STAGES];
    tex_wrap_t   tex_wrap       [NUM_STAGES];
    dcr_data_t   raster_tbuf_addr;
    dcr_data_t   raster_tile_count;
    dcr_data_t   raster_pbuf_addr;
    dcr_data_t   raster_pbuf_stride;
    dcr_data_t   rop_cbuf_addr;
    dcr_data_t   rop_cbuf_pitch;
    dcr_data_t   rop_zbuf_addr;
    rop_mask_t   rop_cbuf_writemask;
    blend_mode_t rop_blend_mode;
    logic        state_updated;
    logic        dcr_error;
    dcr_addr_t   dcr_error_addr;
    int          check_count;
    int          error_count;
    logic [31:0] lfsr;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES),
        .DRIVE_DELAY  (DRIVE_DELAY)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    gfx_dcr_top #(.NUM_STAGES(NUM_STAGES)) u_dut (.*);

    tb_gfx_dcr_checker #(.NUM_STAGES(NUM_STAGES)) u_checker (.*);

    // Taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic is_mapped(input dcr_addr_t a);
        return (a == DCR_COMMIT)
            || ((a >= DCR_TEX_BEGIN) && (a < DCR_TEX_END))
            || ((a >= DCR_RASTER_BEGIN) && (a < DCR_RASTER_END))
            || ((a >= DCR_ROP_BEGIN) && (a < DCR_ROP_END));
    endfunction

    // Maps index 0..14 onto every bank register including TEX_STAGE.
    function automatic dcr_addr_t register_address(input logic [3:0] index);
        if (index < 4'd6) begin
            return DCR_TEX_BEGIN + dcr_addr_t'(index);
        end else if (index < 4'd10) begin
            return DCR_RASTER_BEGIN + dcr_addr_t'(index - 4'd6);
        end else begin
            return DCR_ROP_BEGIN + dcr_addr_t'(index - 4'd10);
        end
    endfunction

    task automatic pick_unmapped(output dcr_addr_t addr);
        logic [31:0] bits;
        draw_bits(2, bits);
        case (bits[1:0])
            2'd0: begin
                addr = DCR_COMMIT;
                while (is_mapped(addr)) begin
                    draw_bits(12, bits);
                    addr = bits[11:0];
                end
            end
            2'd1: addr = DCR_TEX_END;       // First address past each bank.
            2'd2: addr = DCR_RASTER_END;
            default: addr = DCR_ROP_END;
        endcase
    endtask

    task automatic drive_random_cycle();
        logic [31:0] bits;
        logic [31:0] data;
        draw_bits(2, bits);
        dcr_wr_valid = (bits[1:0] != 2'b00);
        draw_bits(4, bits);
        if (bits[3:0] < 4'd2) begin
            dcr_wr_addr = DCR_COMMIT;
        end else if (bits[3:0] == 4'd2) begin
            pick_unmapped(dcr_wr_addr);
        end else begin
            draw_bits(4, bits);
            dcr_wr_addr = register_address(bits[3:0] % 4'd15);
        end
        draw_bits(32, data);
        dcr_wr_data = data;
    endtask

    initial begin
        dcr_wr_valid = 1'b0;
        dcr_wr_addr  = '0;
        dcr_wr_data  = '0;
        lfsr         = 32'hbbb;
        wait (reset === 1'b0);
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            drive_random_cycle();
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        dcr_wr_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d clock periods", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
gfx_dcr_pkg.sv
gfx_state_if.sv
dcr_write_decoder.sv
tex_dcr_bank.sv
raster_dcr_bank.sv
rop_dcr_bank.sv
dcr_state_commit.sv
gfx_dcr_top.sv
tb_clock_gen.sv
tb_gfx_dcr_checker.sv
tb_gfx_dcr.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP       = tb_gfx_dcr
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
